// File: sources.f
+incdir+src
src/pixel_pkg.sv
src/local_fifo.sv
src/hit_window.sv
src/event_router.sv
src/pixel_readout_top.sv
verif/tb_pixel_readout.sv

// File: run_sim.sh
#!/bin/sh
# build and run the readout testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sources.f --top-module tb_pixel_readout -o tb_sim \
    || { echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || echo "simulator returned a failing status"
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "FAIL"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "FAIL: no result line in sim.log"; exit 1; }
echo "PASS"

// File: verif/readout_input.txt
# name mode threshold timeout(hex clocks) mask stall, then payloads ch0..ch7
# payload is hex timestamp[11:0] then adc[7:0]; mode 1 = integration; stall 1 = pop stalls
plain_all          0 1 04 ff 0 1a0c3 1a117 2b2ff 3c300 4d45a 5e5e1 6f6a9 7077e
plain_sparse       0 1 04 a5 0 80101 91202 a2303 b3404 c4505 d5606 e6707 f7808
integ_accept       1 3 14 2d 0 00a11 01b22 02c33 03d44 04e55 05f66 06077 07188
integ_exact        1 2 0c 81 0 fff00 00000 12345 6789a bcdef 13579 2468a fedcb
integ_reject       1 5 10 16 0 11111 22222 33333 44444 55555 66666 77777 88888
after_reject       0 1 04 40 0 aaaaa bbbbb ccccc ddddd eeeee fffff 0f0f0 abcde
integ_reject_wide  1 8 1e 7f 0 01010 02020 03030 04040 05050 06060 07070 08080
stall_full         0 1 08 ff 1 9c001 9c102 9c204 9c308 9c410 9c520 9c640 9c780
stall_integ        1 6 19 ff 1 00fff 11eee 22ddd 33ccc 44bbb 55aaa 66999 77888
plain_single       0 1 04 01 0 5a5a5 00000 00000 00000 00000 00000 00000 00000

// File: verif/tb_pixel_readout.sv
// vectors come from verif/readout_input.txt relative to the project root; one hit per masked channel
`default_nettype none
`include "pixel_consts.svh"

module tb_pixel_readout;

    localparam int CH_W  = $clog2(`NUM_CHANNELS);
    localparam int PAY_W = `TIMESTAMP_WIDTH + `ADC_WIDTH;

    typedef struct packed {
        logic                                integrate_mode;
        logic [`THRESHOLD_WIDTH-1:0]         threshold;
        logic [`TIMEOUT_WIDTH-1:0]           timeout;
        logic [`NUM_CHANNELS-1:0]            mask;     // channels written this test
        logic                                stall;    // random pop stalls
        logic [`NUM_CHANNELS-1:0][PAY_W-1:0] payload;  // timestamp then adc
    } test_vec_t;

    logic                     clk;
    logic                     reset_n;
    pixel_pkg::router_cfg_t   cfg;
    pixel_pkg::hit_t          hit_in [`NUM_CHANNELS];
    logic [`NUM_CHANNELS-1:0] hit_write;
    logic                     event_pop;
    pixel_pkg::routed_event_t event_out;
    logic                     event_valid;

    test_vec_t                vec_q [$];
    string                    name_q [$];
    pixel_pkg::routed_event_t exp_q [$];          // reference word list
    integer                   seed = 32'h511;
    int                       max_timeout = 0;
    bit                       vectors_loaded = 1'b0;
    longint                   watchdog_limit;

    pixel_readout_top dut0 (
        .clk         (clk),
        .reset_n     (reset_n),
        .cfg         (cfg),
        .hit_in      (hit_in),
        .hit_write   (hit_write),
        .event_pop   (event_pop),
        .event_out   (event_out),
        .event_valid (event_valid)
    );

    always #5 clk = ~clk;  // period 10

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped at first error");
    endtask

    function automatic logic odd_parity(input pixel_pkg::hit_t h);
        int ones;
        ones = 0;
        for (int b = 0; b < $bits(h); b++) begin
            if (h[b]) ones++;
        end
        return (ones % 2 == 0);  // set when the hit alone is even
    endfunction

    ////////////////////////////////////////
    // vector file and reference model
    task automatic load_vectors();
        int        fd;
        int        n;
        int        f_mode, f_thr, f_tmo, f_mask, f_stall;
        int        pv [8];
        string     line;
        string     name;
        test_vec_t v;
        fd = $fopen("verif/readout_input.txt", "r");
        if (fd == 0) report_failure("cannot open verif/readout_input.txt");
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != "#") begin  // skip blanks and comments
                n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h", name, f_mode,
                            f_thr, f_tmo, f_mask, f_stall, pv[0], pv[1], pv[2], pv[3],
                            pv[4], pv[5], pv[6], pv[7]);
                if (n != 14) report_failure($sformatf("malformed vector line: %s", line));
                v.integrate_mode = f_mode[0];
                v.threshold      = f_thr[`THRESHOLD_WIDTH-1:0];
                v.timeout        = f_tmo[`TIMEOUT_WIDTH-1:0];
                v.mask           = f_mask[`NUM_CHANNELS-1:0];
                v.stall          = f_stall[0];
                for (int i = 0; i < `NUM_CHANNELS; i++) v.payload[i] = pv[i][PAY_W-1:0];
                if (int'(v.timeout) > max_timeout) max_timeout = int'(v.timeout);
                vec_q.push_back(v);
                name_q.push_back(name);
            end
        end
        $fclose(fd);
        if (vec_q.size() == 0) report_failure("vector file holds no tests");
    endtask

    task automatic build_expected(input test_vec_t v);
        pixel_pkg::routed_event_t w;
        int                       hits;
        hits = 0;
        exp_q.delete();
        for (int i = 0; i < `NUM_CHANNELS; i++) if (v.mask[i]) hits++;
        if (!v.integrate_mode || hits >= int'(v.threshold)) begin  // else drained, nothing out
            for (int i = 0; i < `NUM_CHANNELS; i++) begin
                if (v.mask[i]) begin                                 // ascending channel order
                    w.hit.channel_id = CH_W'(i);
                    w.hit.timestamp  = v.payload[i][PAY_W-1:`ADC_WIDTH];
                    w.hit.adc        = v.payload[i][`ADC_WIDTH-1:0];
                    w.parity         = odd_parity(w.hit);
                    exp_q.push_back(w);
                end
            end
        end
    endtask

    task automatic compare_word(input string name, input int idx,
                                input pixel_pkg::routed_event_t actual);
        assert (^actual == 1'b1) else begin
            report_failure($sformatf("mismatch in %s, word %0d parity: expected 1, actual %0d",
                                     name, idx, ^actual));
        end
        assert (actual == exp_q[idx]) else begin
            report_failure($sformatf("mismatch in %s, word %0d: expected %h, actual %h",
                                     name, idx, exp_q[idx], actual));
        end
    endtask

    ////////////////////////////////////////
    // one test: config, hit burst, drain
    task automatic run_test(input int idx);
        test_vec_t       v;
        string           name;
        pixel_pkg::hit_t h;
        int              got;
        int              idle;
        int              stall_left;
        logic            pop_next;
        v    = vec_q[idx];
        name = name_q[idx];
        build_expected(v);
        got        = 0;
        idle       = 0;
        stall_left = v.stall ? 24 + int'({$random(seed)} % 8) : 0;  // long first stall fills chip
        @(posedge clk);
        cfg.integrate_mode <= v.integrate_mode;
        cfg.hit_threshold  <= v.threshold;
        cfg.timeout        <= v.timeout;
        event_pop          <= 1'b0;
        @(posedge clk);
        for (int i = 0; i < `NUM_CHANNELS; i++) begin
            h.channel_id = CH_W'(i);
            h.timestamp  = v.payload[i][PAY_W-1:`ADC_WIDTH];
            h.adc        = v.payload[i][`ADC_WIDTH-1:0];
            hit_in[i]   <= h;
        end
        hit_write <= v.mask;  // all hits in one cycle
        @(posedge clk);
        hit_write <= '0;
        while (got < exp_q.size() || idle < int'(v.timeout) + 10) begin  // quiet after last word
            @(negedge clk);
            assert (!(event_valid && got == exp_q.size())) else begin
                report_failure($sformatf("test %s: chip FIFO shows a word beyond the %0d expected",
                                         name, got));
            end
            if (event_pop && event_valid) begin  // head leaves on next edge
                compare_word(name, got, event_out);
                got++;
                if (v.stall) stall_left = int'({$random(seed)} % 4);
            end else if (stall_left > 0) begin
                stall_left--;
            end
            if (got == exp_q.size()) idle++;
            pop_next = event_valid && (stall_left == 0);
            @(posedge clk);
            event_pop <= pop_next;
        end
    endtask

    initial begin
        clk       = 1'b0;
        reset_n   = 1'b0;
        cfg       = '0;
        hit_write = '0;
        event_pop = 1'b0;
        for (int i = 0; i < `NUM_CHANNELS; i++) hit_in[i] = '0;
        load_vectors();
        watchdog_limit = longint'(vec_q.size()) * longint'(max_timeout + 40) * 10;
        vectors_loaded = 1'b1;
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;
        for (int t = 0; t < vec_q.size(); t++) run_test(t);
        $display("NO ERRORS");
        $finish;
    end

    // watchdog, budget scales with test count and longest window
    initial begin
        wait (vectors_loaded);
        #(watchdog_limit);
        report_failure($sformatf("timeout: run did not finish within %0d time units",
                                 watchdog_limit));
    end

endmodule

`default_nettype wire

// File: src/pixel_readout_top.sv
// cfg must stay steady while a hit is in flight; hit writes to a full channel FIFO are lost
`default_nettype none
`include "pixel_consts.svh"

module pixel_readout_top (
    input  wire logic                     clk,
    input  wire logic                     reset_n,
    input  wire pixel_pkg::router_cfg_t   cfg,
    input  wire pixel_pkg::hit_t          hit_in [`NUM_CHANNELS],  // one per channel
    input  wire logic [`NUM_CHANNELS-1:0] hit_write,               // write strobes
    input  wire logic                     event_pop,               // pop chip FIFO head
    output pixel_pkg::routed_event_t      event_out,
    output logic                          event_valid               // chip FIFO not empty
);

    logic [`NUM_CHANNELS-1:0] channel_empty;
    logic [`NUM_CHANNELS-1:0] channel_read_n;
    pixel_pkg::hit_t          channel_head [`NUM_CHANNELS];
    logic                     window_start;
    logic                     window_accept;
    logic                     window_done;
    pixel_pkg::routed_event_t event_word;
    logic                     load_event;
    logic                     chip_empty;
    logic                     chip_full;

    ////////////////////////////////////////
    // channel FIFO bank
    for (genvar i = 0; i < `NUM_CHANNELS; i++) begin : g_channel
        local_fifo #(
            .payload_t (pixel_pkg::hit_t),
            .DEPTH     (`LOCAL_FIFO_DEPTH)
        ) u_fifo (
            .clk      (clk),
            .reset_n  (reset_n),
            .write    (hit_write[i]),
            .data_in  (hit_in[i]),
            .read_n   (channel_read_n[i]),
            .data_out (channel_head[i]),
            .empty    (channel_empty[i]),
            .full     ()                 // overflow handled inside
        );
    end

    hit_window u_window (
        .clk           (clk),
        .reset_n       (reset_n),
        .cfg           (cfg),
        .channel_empty (channel_empty),
        .window_start  (window_start),
        .window_accept (window_accept),
        .window_done   (window_done)
    );

    event_router u_router (
        .clk           (clk),
        .reset_n       (reset_n),
        .channel_empty (channel_empty),
        .channel_head  (channel_head),
        .window_accept (window_accept),
        .window_done   (window_done),
        .chip_full     (chip_full),
        .window_start  (window_start),
        .read_n        (channel_read_n),
        .event_word    (event_word),
        .load_event    (load_event)
    );

    ////////////////////////////////////////
    // shared chip FIFO
    local_fifo #(
        .payload_t (pixel_pkg::routed_event_t),
        .DEPTH     (`CHIP_FIFO_DEPTH)
    ) u_chip_fifo (
        .clk      (clk),
        .reset_n  (reset_n),
        .write    (load_event),
        .data_in  (event_word),
        .read_n   (~event_pop),   // pop is active high outside
        .data_out (event_out),
        .empty    (chip_empty),
        .full     (chip_full)
    );

    assign event_valid = ~chip_empty;

endmodule

`default_nettype wire

// File: src/event_router.sv
// serves only channels caught in the snapshot; new hits on other channels wait for the next pass
`default_nettype none
`include "pixel_consts.svh"

module event_router (
    input  wire logic                     clk,
    input  wire logic                     reset_n,
    input  wire logic [`NUM_CHANNELS-1:0] channel_empty,
    input  wire pixel_pkg::hit_t          channel_head [`NUM_CHANNELS],
    input  wire logic                     window_accept,
    input  wire logic                     window_done,
    input  wire logic                     chip_full,     // back-pressure from chip FIFO
    output logic                          window_start,
    output logic [`NUM_CHANNELS-1:0]      read_n,        // low pops a channel
    output pixel_pkg::routed_event_t      event_word,    // word with parity
    output logic                          load_event     // write strobe to chip FIFO
);

    localparam int CH_W = $clog2(`NUM_CHANNELS);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_INTEGRATE,
        ST_READ,
        ST_LATCH,
        ST_CLEANUP
    } state_t;

    state_t                   state;
    state_t                   next_state;
    logic [`NUM_CHANNELS-1:0] empty_hold;  // snapshot, 1 = nothing to serve
    logic [CH_W-1:0]          first_idx;   // lowest waiting channel in snapshot
    logic [CH_W-1:0]          sel;         // channel read last cycle
    pixel_pkg::hit_t          sel_head;

    ////////////////////////////////////////
    // priority pick, lowest index wins
    always_comb begin
        first_idx = '0;
        for (int i = `NUM_CHANNELS - 1; i >= 0; i--) begin
            if (!empty_hold[i]) begin
                first_idx = CH_W'(i);
            end
        end
    end

    assign sel_head     = channel_head[sel];
    assign window_start = (state == ST_IDLE) && !(&channel_empty);  // open on any hit

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (!(&channel_empty)) next_state = ST_INTEGRATE;
            end
            ST_INTEGRATE: begin
                if (window_accept)    next_state = ST_READ;     // accept beats timeout
                else if (window_done) next_state = ST_CLEANUP;
            end
            ST_READ: begin
                next_state = ST_LATCH;
            end
            ST_LATCH: begin
                if (!chip_full) begin                          // hold while full
                    next_state = (&empty_hold) ? ST_IDLE : ST_READ;
                end
            end
            ST_CLEANUP: begin
                next_state = ST_IDLE;
            end
            default: next_state = ST_IDLE;
        endcase
    end

    ////////////////////////////////////////
    // registered strobes and snapshot
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            read_n     <= '1;
            load_event <= 1'b0;
            empty_hold <= '1;
            sel        <= '0;
        end else begin
            read_n     <= '1;                                // pulses last one cycle
            load_event <= (state == ST_LATCH) && !chip_full;  // chip has room
            case (next_state)
                ST_INTEGRATE: begin
                    empty_hold <= channel_empty;   // follow flags while integrating
                end
                ST_READ: begin
                    read_n[first_idx]     <= 1'b0;  // pop lowest waiting
                    empty_hold[first_idx] <= 1'b1;  // mark served
                    sel                   <= first_idx;
                end
                ST_CLEANUP: begin
                    read_n <= empty_hold;           // drop one hit per busy channel
                end
                default: ;
            endcase
        end
    end

    // head is still valid on the pop edge, capture it once per read
    always_ff @(posedge clk) begin
        if (state == ST_READ) begin
            event_word.parity <= ~^sel_head;  // odd parity
            event_word.hit    <= sel_head;
        end
    end

endmodule

`default_nettype wire

// File: src/hit_window.sv
// cfg is a static level during a window; accept and done hold until the next window_start
`default_nettype none
`include "pixel_consts.svh"

module hit_window (
    input  wire logic                     clk,
    input  wire logic                     reset_n,
    input  wire pixel_pkg::router_cfg_t   cfg,
    input  wire logic [`NUM_CHANNELS-1:0] channel_empty,  // live flags of the bank
    input  wire logic                     window_start,   // pulse from router
    output logic                          window_accept,  // enough channels fired
    output logic                          window_done     // timer ran out
);

    localparam int CNT_W = $clog2(`NUM_CHANNELS + 1);

    logic [CNT_W-1:0]          hit_sum;  // busy channels this cycle
    logic [`TIMEOUT_WIDTH-1:0] timer;    // clocks since start

    always_comb begin
        hit_sum = '0;
        for (int i = 0; i < `NUM_CHANNELS; i++) begin
            hit_sum = hit_sum + CNT_W'(!channel_empty[i]);  // count non-empty
        end
    end

    ////////////////////////////////////////
    // window control
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            timer         <= '0;
            window_accept <= 1'b0;
            window_done   <= 1'b0;
        end else if (window_start) begin
            timer         <= '0;
            window_accept <= !cfg.integrate_mode;  // plain mode passes at once
            window_done   <= !cfg.integrate_mode;
        end else if (!window_accept && !window_done) begin
            if (hit_sum >= cfg.hit_threshold) begin
                window_accept <= 1'b1;             // coincidence reached
            end else if (timer >= cfg.timeout) begin
                window_done <= 1'b1;               // give up, router drains
            end else begin
                timer <= timer + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/local_fifo.sv
// DEPTH must be at least 2; a write when full is dropped and a read pulse when empty is ignored
`default_nettype none
`include "pixel_consts.svh"

module local_fifo #(
    parameter type payload_t = logic [7:0],   // word type held in the buffer
    parameter int  DEPTH     = `LOCAL_FIFO_DEPTH
) (
    input  wire logic clk,
    input  wire logic reset_n,     // async, active low
    input  wire logic write,       // one-cycle write strobe
    input  wire payload_t data_in,
    input  wire logic read_n,      // low pops the head
    output payload_t  data_out,    // head word, combinational
    output logic      empty,
    output logic      full
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];  // storage, no reset
    logic [PTR_W-1:0] wr_ptr;       // next slot to write
    logic [PTR_W-1:0] rd_ptr;       // head slot
    logic [CNT_W-1:0] count;        // occupancy
    logic             do_write;
    logic             do_read;

    assign do_write = write && !full;     // drop on full
    assign do_read  = !read_n && !empty;  // ignore on empty
    assign empty    = (count == '0);
    assign full     = (count == CNT_W'(DEPTH));
    assign data_out = mem[rd_ptr];        // head shown without a read

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= data_in;
        end
    end

    ////////////////////////////////////////
    // pointers and count
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // wrap
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;  // both or neither, no change
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/pixel_pkg.sv
// packed word formats of the readout path; field order fixes the bit layout seen by the testbench
`default_nettype none
`include "pixel_consts.svh"

package pixel_pkg;

    ////////////////////////////////////////
    // one hit from a channel digitizer
    typedef struct packed {
        logic [$clog2(`NUM_CHANNELS)-1:0] channel_id;  // source channel, msbs
        logic [`TIMESTAMP_WIDTH-1:0]      timestamp;   // hit time
        logic [`ADC_WIDTH-1:0]            adc;         // charge, lsbs
    } hit_t;

    ////////////////////////////////////////
    // word stored in the chip FIFO
    typedef struct packed {
        logic parity;  // odd parity over hit
        hit_t hit;     // hit as read from channel
    } routed_event_t;

    // static levels from the outside world
    typedef struct packed {
        logic                        integrate_mode;  // 1 = wait for coincidence
        logic [`THRESHOLD_WIDTH-1:0] hit_threshold;   // min busy channels
        logic [`TIMEOUT_WIDTH-1:0]   timeout;         // window length in clocks
    } router_cfg_t;

endpackage

`default_nettype wire

// File: src/pixel_consts.svh
// sizes shared by RTL and testbench; NUM_CHANNELS is a power of two so the channel id fills its field
`ifndef PIXEL_CONSTS_SVH
`define PIXEL_CONSTS_SVH

////////////////////////////////////////
// array sizes
`define NUM_CHANNELS      8   // pixel channels on the chip
`define LOCAL_FIFO_DEPTH  4   // hits held per channel
`define CHIP_FIFO_DEPTH   8   // routed words held for readout

////////////////////////////////////////
// field widths
`define ADC_WIDTH         8   // digitized charge
`define TIMESTAMP_WIDTH   12  // hit time tag
`define THRESHOLD_WIDTH   4   // channels needed to accept
`define TIMEOUT_WIDTH     8   // integration window in clocks

`endif
